// File: common/apb_defines.svh
`ifndef APB_DEFINES_SVH
`define APB_DEFINES_SVH

// bus widths
`define APB_ADDR_W 32
`define APB_DATA_W 32
`define APB_STRB_W (`APB_DATA_W / 8)

// sram target, byte addresses from 4 * words upward are out of range
`define APB_SRAM_WORDS 64

// latency ratio in fixed point with APB_DELAY_FRAC_BITS fraction bits
`define APB_DELAY_FRAC_BITS 10
`define APB_DELAY_SCALE 2048     // x2, never below 1 << frac bits
`define APB_DELAY_CNT_W 32

// 1 stretches target responses, 0 turns the delayer into plain wiring
`define APB_DELAY_ENABLE 1

`endif

// File: common/apb_pkg.sv
`include "apb_defines.svh"

package apb_pkg;

    // request side of an apb link, driven by the requester
    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [2:0]              pprot;
        logic [`APB_ADDR_W-1:0]  paddr;
        logic [`APB_DATA_W-1:0]  pwdata;
        logic [`APB_STRB_W-1:0]  pstrb;
    } apb_req_t;

    // response side, driven by the target
    typedef struct packed {
        logic                    pready;
        logic [`APB_DATA_W-1:0]  prdata;
        logic                    pslverr;
    } apb_rsp_t;

    // delayer FSM
    typedef enum logic [1:0] {
        st_idle    = 2'd0,    // no access phase seen yet
        st_active  = 2'd1,    // counting target wait cycles
        st_hold    = 2'd2,    // response latched, stretch running
        st_release = 2'd3     // upstream pready cycle
    } delay_state_t;

endpackage

// File: src/apb_requester.sv
`timescale 1ns/1ps
`include "apb_defines.svh"

module apb_requester (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    cmd_valid,
    input  logic [`APB_ADDR_W-1:0]  cmd_addr,
    input  logic                    cmd_write,
    input  logic [`APB_DATA_W-1:0]  cmd_wdata,
    input  logic [`APB_STRB_W-1:0]  cmd_strb,
    output logic                    cmd_busy,
    output logic                    rsp_valid,
    output logic [`APB_DATA_W-1:0]  rsp_rdata,
    output logic                    rsp_slverr,
    output apb_pkg::apb_req_t       bus_req,
    input  apb_pkg::apb_rsp_t       bus_rsp
);

    typedef enum logic [1:0] {
        req_idle   = 2'd0,
        req_setup  = 2'd1,
        req_access = 2'd2
    } req_state_t;

    req_state_t              state;
    logic                    accept;
    logic                    done;
    logic [`APB_ADDR_W-1:0]  addr_q;
    logic                    write_q;
    logic [`APB_DATA_W-1:0]  wdata_q;
    logic [`APB_STRB_W-1:0]  strb_q;

    assign cmd_busy = (state != req_idle);
    assign accept   = cmd_valid & ~cmd_busy;    // strobes while busy are dropped
    assign done     = (state == req_access) & bus_rsp.pready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state     <= req_idle;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= done;
            case (state)
                req_idle: begin
                    if (accept) begin
                        state <= req_setup;
                    end
                end
                req_setup:  state <= req_access;
                req_access: begin
                    if (bus_rsp.pready) begin
                        state <= req_idle;
                    end
                end
                default:    state <= req_idle;
            endcase
        end
    end

    // command payload, held stable for setup and access
    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q  <= cmd_addr;
            write_q <= cmd_write;
            wdata_q <= cmd_wdata;
            strb_q  <= cmd_strb;
        end
    end

    always_ff @(posedge clock) begin
        if (done) begin
            rsp_rdata  <= bus_rsp.prdata;
            rsp_slverr <= bus_rsp.pslverr;
        end
    end

    always_comb begin
        bus_req.psel    = (state != req_idle);
        bus_req.penable = (state == req_access);
        bus_req.pwrite  = write_q;
        bus_req.pprot   = 3'b000;    // normal, secure, data
        bus_req.paddr   = addr_q;
        bus_req.pwdata  = wdata_q;
        bus_req.pstrb   = strb_q;
    end

endmodule

// File: apb_delayer/apb_delayer.sv
`timescale 1ns/1ps
`include "apb_defines.svh"

module apb_delayer (
    input  logic               clock,
    input  logic               reset,
    input  apb_pkg::apb_req_t  up_req,
    output apb_pkg::apb_rsp_t  up_rsp,
    output apb_pkg::apb_req_t  dn_req,
    input  apb_pkg::apb_rsp_t  dn_rsp
);

    localparam int CNT_W    = `APB_DELAY_CNT_W;
    localparam int PROD_W   = 2 * CNT_W;
    localparam bit SCALE_EN = (`APB_DELAY_ENABLE != 0);

    generate
        if (SCALE_EN) begin : gen_scale
            apb_pkg::delay_state_t   state;
            logic [CNT_W-1:0]        wait_cnt;       // downstream cycles with pready low
            logic [CNT_W-1:0]        hold_cnt;
            logic [PROD_W-1:0]       scaled_wait;
            logic [CNT_W-1:0]        hold_next;
            logic [`APB_DATA_W-1:0]  rdata_q;
            logic                    slverr_q;
            logic                    access;
            logic                    masked;
            logic                    release_cyc;

            assign access      = up_req.psel & up_req.penable;
            assign release_cyc = (state == apb_pkg::st_release);
            assign masked      = (state == apb_pkg::st_hold) | release_cyc;

            // extra cycles = floor(n * scale) - n, n itself is already spent
            assign scaled_wait = (PROD_W'(wait_cnt) * PROD_W'(`APB_DELAY_SCALE))
                                 >> `APB_DELAY_FRAC_BITS;
            assign hold_next   = scaled_wait[CNT_W-1:0] - wait_cnt;

            // the target has already answered, keep it from seeing the transfer again
            always_comb begin
                dn_req         = up_req;
                dn_req.psel    = up_req.psel & ~masked;
                dn_req.penable = up_req.penable & ~masked;
            end

            always_comb begin
                up_rsp.pready  = release_cyc;
                up_rsp.prdata  = release_cyc ? rdata_q : '0;
                up_rsp.pslverr = release_cyc & slverr_q;
            end

            always_ff @(posedge clock) begin
                if (!reset) begin
                    state    <= apb_pkg::st_idle;
                    wait_cnt <= '0;
                    hold_cnt <= '0;
                end else begin
                    case (state)
                        apb_pkg::st_idle, apb_pkg::st_active: begin
                            if (access) begin
                                if (dn_rsp.pready) begin
                                    wait_cnt <= '0;
                                    hold_cnt <= hold_next;
                                    if (hold_next == '0) begin
                                        state <= apb_pkg::st_release;
                                    end else begin
                                        state <= apb_pkg::st_hold;
                                    end
                                end else begin
                                    wait_cnt <= wait_cnt + 1'b1;
                                    state    <= apb_pkg::st_active;
                                end
                            end
                        end
                        apb_pkg::st_hold: begin
                            hold_cnt <= hold_cnt - 1'b1;
                            if (hold_cnt == CNT_W'(1)) begin
                                state <= apb_pkg::st_release;
                            end
                        end
                        apb_pkg::st_release: state <= apb_pkg::st_idle;
                        default:             state <= apb_pkg::st_idle;
                    endcase
                end
            end

            always_ff @(posedge clock) begin
                if (access & ~masked & dn_rsp.pready) begin
                    rdata_q  <= dn_rsp.prdata;
                    slverr_q <= dn_rsp.pslverr;
                end
            end
        end else begin : gen_bypass
            assign dn_req = up_req;
            assign up_rsp = dn_rsp;
        end
    endgenerate

endmodule

// File: src/apb_sram_target.sv
`timescale 1ns/1ps
`include "apb_defines.svh"

module apb_sram_target (
    input  logic               clock,
    input  logic               reset,
    input  apb_pkg::apb_req_t  req,
    output apb_pkg::apb_rsp_t  rsp
);

    localparam int IDX_W = $clog2(`APB_SRAM_WORDS);

    logic [`APB_DATA_W-1:0]  mem [`APB_SRAM_WORDS];
    logic [2:0]              wait_cnt;
    logic [IDX_W-1:0]        idx;
    logic                    in_range;
    logic                    setup;
    logic                    access;
    logic                    done;

    assign setup    = req.psel & ~req.penable;
    assign access   = req.psel & req.penable;
    assign done     = access & (wait_cnt == 3'd0);
    assign idx      = req.paddr[IDX_W+1:2];
    assign in_range = (req.paddr[`APB_ADDR_W-1:IDX_W+2] == '0);

    // wait states come from address bits 4:2, loaded while in setup
    always_ff @(posedge clock) begin
        if (!reset) begin
            wait_cnt <= 3'd0;
        end else if (setup) begin
            wait_cnt <= req.paddr[4:2];
        end else if (access && wait_cnt != 3'd0) begin
            wait_cnt <= wait_cnt - 3'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (done & req.pwrite & in_range) begin
            for (int b = 0; b < `APB_STRB_W; b++) begin
                if (req.pstrb[b]) begin
                    mem[idx][b*8 +: 8] <= req.pwdata[b*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        rsp.pready  = done;
        rsp.pslverr = done & ~in_range;
        rsp.prdata  = (done & ~req.pwrite & in_range) ? mem[idx] : '0;    // writes read back zero
    end

endmodule

// File: src/apb_delay_subsys.sv
`timescale 1ns/1ps
`include "apb_defines.svh"

module apb_delay_subsys (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    cmd_valid,
    input  logic [`APB_ADDR_W-1:0]  cmd_addr,
    input  logic                    cmd_write,
    input  logic [`APB_DATA_W-1:0]  cmd_wdata,
    input  logic [`APB_STRB_W-1:0]  cmd_strb,
    output logic                    cmd_busy,
    output logic                    rsp_valid,
    output logic [`APB_DATA_W-1:0]  rsp_rdata,
    output logic                    rsp_slverr
);

    apb_pkg::apb_req_t  up_req;
    apb_pkg::apb_rsp_t  up_rsp;
    apb_pkg::apb_req_t  dn_req;
    apb_pkg::apb_rsp_t  dn_rsp;

    apb_requester apb_requester_inst (
        .clock      (clock),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_addr   (cmd_addr),
        .cmd_write  (cmd_write),
        .cmd_wdata  (cmd_wdata),
        .cmd_strb   (cmd_strb),
        .cmd_busy   (cmd_busy),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_slverr (rsp_slverr),
        .bus_req    (up_req),
        .bus_rsp    (up_rsp)
    );

    apb_delayer apb_delayer_inst (
        .clock  (clock),
        .reset  (reset),
        .up_req (up_req),
        .up_rsp (up_rsp),
        .dn_req (dn_req),
        .dn_rsp (dn_rsp)
    );

    apb_sram_target apb_sram_target_inst (
        .clock (clock),
        .reset (reset),
        .req   (dn_req),
        .rsp   (dn_rsp)
    );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    localparam int HALF_PERIOD = 20;    // 40 ns clock
    localparam int RESET_CYCLES = 8;

    initial begin
        clock = 1'b0;
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b1;
    end

    always #HALF_PERIOD clock = ~clock;

endmodule

// File: sim/apb_delay_subsys_tb.sv
`timescale 1ns/1ps
`include "apb_defines.svh"

module apb_delay_subsys_tb;

    localparam int N_WORDS   = `APB_SRAM_WORDS;
    localparam int IDX_W     = $clog2(N_WORDS);
    localparam int N_PARTIAL = 32;
    localparam int N_OOR     = 4;
    localparam int N_CMDS    = 2 * N_WORDS + 2 * N_PARTIAL + 3 * N_OOR;
    localparam int TIMEOUT   = N_CMDS * 40 + 200;

    logic                    clock;
    logic                    reset;
    logic                    cmd_valid;
    logic [`APB_ADDR_W-1:0]  cmd_addr;
    logic                    cmd_write;
    logic [`APB_DATA_W-1:0]  cmd_wdata;
    logic [`APB_STRB_W-1:0]  cmd_strb;
    logic                    cmd_busy;
    logic                    rsp_valid;
    logic [`APB_DATA_W-1:0]  rsp_rdata;
    logic                    rsp_slverr;

    logic [`APB_DATA_W-1:0]  ref_mem [N_WORDS];
    logic [31:0]             rng_state;
    logic                    pending;
    logic                    seen_cmd;
    logic [`APB_DATA_W-1:0]  exp_rdata;
    logic                    exp_slverr;
    int                      exp_lat;
    int                      lat_cnt;      // current cycle number, accept cycle is 1
    int                      issued = 0;
    int                      accepted = 0;
    int                      responses = 0;
    int                      mismatch_errors = 0;
    int                      other_errors = 0;
    int                      cycle_cnt = 0;

    tb_clock_gen tb_clock_gen_inst (
        .clock (clock),
        .reset (reset)
    );

    apb_delay_subsys apb_delay_subsys_inst (
        .clock      (clock),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_addr   (cmd_addr),
        .cmd_write  (cmd_write),
        .cmd_wdata  (cmd_wdata),
        .cmd_strb   (cmd_strb),
        .cmd_busy   (cmd_busy),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_slverr (rsp_slverr)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // reference model of one accepted command, wait n from address bits 4:2
    task automatic record_cmd();
        int         n;
        logic [IDX_W-1:0] idx;
        logic       in_range;
        n        = cmd_addr[4:2];
        idx      = cmd_addr[IDX_W+1:2];
        in_range = (cmd_addr < 4 * N_WORDS);
        exp_lat    <= 2 * n + 5;    // target wait doubled by the x2 ratio
        exp_slverr <= ~in_range;
        if (cmd_write || !in_range) begin
            exp_rdata <= '0;
        end else begin
            exp_rdata <= ref_mem[idx];
        end
        if (cmd_write && in_range) begin
            for (int b = 0; b < `APB_STRB_W; b++) begin
                if (cmd_strb[b]) begin
                    ref_mem[idx][b*8 +: 8] = cmd_wdata[b*8 +: 8];
                end
            end
        end
        pending  <= 1'b1;
        seen_cmd <= 1'b1;
        lat_cnt  <= 2;
        accepted <= accepted + 1;
    endtask

    always @(posedge clock) begin
        if (!reset) begin
            pending  <= 1'b0;
            seen_cmd <= 1'b0;
            lat_cnt  <= 0;
        end else begin
            lat_cnt <= lat_cnt + 1;
            if (rsp_valid) begin
                pending   <= 1'b0;
                responses <= responses + 1;
            end
            if (cmd_valid && !cmd_busy) begin
                record_cmd();
            end
        end
    end

    idle_after_reset: assert property (@(posedge clock) disable iff (!reset)
        !seen_cmd |-> (!rsp_valid && !cmd_busy))
        else begin
            other_errors++;
            $display("rsp_valid or cmd_busy went high before the first command");
        end

    rdata_check: assert property (@(posedge clock) disable iff (!reset)
        rsp_valid |-> (rsp_rdata === exp_rdata))
        else begin
            mismatch_errors++;
            $display("mismatch rsp_rdata: got %h expected %h",
                     $sampled(rsp_rdata), $sampled(exp_rdata));
        end

    slverr_check: assert property (@(posedge clock) disable iff (!reset)
        rsp_valid |-> (rsp_slverr === exp_slverr))
        else begin
            mismatch_errors++;
            $display("mismatch rsp_slverr: got %h expected %h",
                     $sampled(rsp_slverr), $sampled(exp_slverr));
        end

    latency_check: assert property (@(posedge clock) disable iff (!reset)
        rsp_valid |-> (lat_cnt == exp_lat))
        else begin
            mismatch_errors++;
            $display("mismatch latency: got %h expected %h",
                     $sampled(lat_cnt), $sampled(exp_lat));
        end

    single_pulse: assert property (@(posedge clock) disable iff (!reset)
        rsp_valid |=> !rsp_valid)
        else begin
            other_errors++;
            $display("rsp_valid stayed high for more than one cycle");
        end

    rsp_has_cmd: assert property (@(posedge clock) disable iff (!reset)
        rsp_valid |-> pending)
        else begin
            other_errors++;
            $display("rsp_valid came without an outstanding command");
        end

    busy_while_pending: assert property (@(posedge clock) disable iff (!reset)
        (pending && !rsp_valid) |-> cmd_busy)
        else begin
            other_errors++;
            $display("cmd_busy dropped while a command was outstanding");
        end

    // one command, optionally followed by a strobe that lands while busy
    task automatic issue_cmd(input logic [31:0] addr, input logic write,
                             input logic [31:0] wdata, input logic [3:0] strb,
                             input bit poke_busy);
        logic [31:0] junk;
        @(posedge clock);
        cmd_valid <= 1'b1;
        cmd_addr  <= addr;
        cmd_write <= write;
        cmd_wdata <= wdata;
        cmd_strb  <= strb;
        @(posedge clock);
        cmd_valid <= 1'b0;
        issued++;
        if (poke_busy) begin
            junk = next_rand();
            @(posedge clock);
            cmd_valid <= 1'b1;
            cmd_addr  <= junk & 32'h0000_00fc;
            cmd_write <= 1'b1;
            cmd_wdata <= ~junk;
            cmd_strb  <= 4'hf;
            @(posedge clock);
            cmd_valid <= 1'b0;
        end
        while (responses != issued) @(posedge clock);
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] r;
        rng_state = 32'hd6eae5e0;
        cmd_valid <= 1'b0;
        cmd_addr  <= '0;
        cmd_write <= 1'b0;
        cmd_wdata <= '0;
        cmd_strb  <= '0;
        while (reset !== 1'b1) @(posedge clock);
        repeat (3) @(posedge clock);    // quiet window after reset

        for (int i = 0; i < N_WORDS; i++) begin
            issue_cmd(i * 4, 1'b1, next_rand(), 4'hf, 1'b0);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            issue_cmd(i * 4, 1'b0, '0, 4'h0, 1'b0);
        end

        for (int i = 0; i < N_PARTIAL; i++) begin
            r    = next_rand();
            addr = r & ((4 * N_WORDS) - 4);
            data = next_rand();
            r    = next_rand();
            issue_cmd(addr, 1'b1, data, r[3:0], (i % 4) == 0);
            issue_cmd(addr, 1'b0, '0, 4'h0, 1'b0);
        end

        for (int i = 0; i < N_OOR; i++) begin
            r    = next_rand();
            addr = (r | (4 * N_WORDS)) & 32'hffff_fffc;
            issue_cmd(addr, 1'b0, '0, 4'h0, 1'b0);
            issue_cmd(addr, 1'b1, next_rand(), 4'hf, 1'b0);
            issue_cmd(addr & ((4 * N_WORDS) - 4), 1'b0, '0, 4'h0, 1'b0);    // aliased word
        end

        repeat (4) @(posedge clock);
        assert (accepted == issued && responses == issued)
            else begin
                other_errors++;
                $display("response count wrong: %0d issued, %0d accepted, %0d responses",
                         issued, accepted, responses);
            end
        $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout: test did not finish within %0d cycles", TIMEOUT);
            $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule

// File: list.f
+incdir+common
common/apb_pkg.sv
src/apb_requester.sv
apb_delayer/apb_delayer.sv
src/apb_sram_target.sv
src/apb_delay_subsys.sv
sim/tb_clock_gen.sv
sim/apb_delay_subsys_tb.sv
